// ==== hw/vga_pkg.sv ====
package vga_pkg;

    typedef enum logic [1:0] {
        MODE_SOLID = 2'd0,  // Background only
        MODE_CHAR  = 2'd1,  // Tiled hex digits
        MODE_PONG  = 2'd2,  // Paddle and ball
        MODE_NOISE = 2'd3   // LFSR speckle
    } mode_e;

    // Byte 3 is first on the SPI wire
    typedef union packed {
        logic [3:0][7:0] bytes;     // SPI view
        struct packed {
            mode_e      mode;       // Bits 31:30
            logic [5:0] fg;         // RGB222 foreground
            logic [5:0] bg;         // RGB222 background
            logic [7:0] char_code;  // Two hex digits
            logic [1:0] scale;      // Log2 pixel size
            logic [7:0] reserved;   // Spare
        } f;                        // Field view
    } cfg_word_u;

    // Char mode, white on black, code 00, scale 1
    localparam logic [31:0] CFG_RESET = 32'h7F00_0000;

    localparam int PADDLE_W    = 4;   // Paddle width in pixels
    localparam int PADDLE_H    = 16;  // Paddle height
    localparam int PADDLE_STEP = 4;   // Pixels per frame
    localparam int BALL_SIZE   = 4;   // Ball square side

endpackage

// ==== hw/vga_beam_if.sv ====
`timescale 1ns/1ps

interface vga_beam_if;
    logic [9:0] x;            // Column
    logic [9:0] y;            // Row
    logic       visible;      // Inside active area
    logic       hsync;        // Active low
    logic       vsync;        // Active low
    logic       frame_start;  // Pulse at 0,0

    modport source (
        output x, y, visible, hsync, vsync, frame_start
    );

    modport sink (
        input x, y, visible, hsync, vsync, frame_start
    );
endinterface

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic       clk,
    input  logic       rst_n,
    vga_beam_if.source beam
);
    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    localparam logic [9:0] H_LAST   = 10'(H_TOTAL - 1);
    localparam logic [9:0] V_LAST   = 10'(V_TOTAL - 1);
    localparam logic [9:0] H_VIS    = 10'(H_VISIBLE);
    localparam logic [9:0] V_VIS    = 10'(V_VISIBLE);
    localparam logic [9:0] HS_START = 10'(H_VISIBLE + H_FRONT);
    localparam logic [9:0] HS_END   = 10'(H_VISIBLE + H_FRONT + H_SYNC);
    localparam logic [9:0] VS_START = 10'(V_VISIBLE + V_FRONT);
    localparam logic [9:0] VS_END   = 10'(V_VISIBLE + V_FRONT + V_SYNC);

    logic [9:0] x_nxt;  // Position one cycle ahead
    logic [9:0] y_nxt;

    always_comb begin
        x_nxt = beam.x + 10'd1;
        y_nxt = beam.y;
        if (beam.x == H_LAST) begin  // Wrap line
            x_nxt = 10'd0;
            y_nxt = (beam.y == V_LAST) ? 10'd0 : beam.y + 10'd1;
        end
    end

    // Decode from next position so all flags line up with x and y
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beam.x           <= H_LAST;  // First step lands on 0,0
            beam.y           <= V_LAST;
            beam.visible     <= 1'b0;
            beam.hsync       <= 1'b1;
            beam.vsync       <= 1'b1;
            beam.frame_start <= 1'b0;
        end else begin
            beam.x           <= x_nxt;
            beam.y           <= y_nxt;
            beam.visible     <= (x_nxt < H_VIS) && (y_nxt < V_VIS);
            beam.hsync       <= !((x_nxt >= HS_START) && (x_nxt < HS_END));
            beam.vsync       <= !((y_nxt >= VS_START) && (y_nxt < VS_END));  // Whole lines
            beam.frame_start <= (x_nxt == 10'd0) && (y_nxt == 10'd0);
        end
    end

    a_beam_range: assert property (@(posedge clk) disable iff (!rst_n)
        (beam.x <= H_LAST) && (beam.y <= V_LAST));

endmodule

// ==== hw/spi_peripheral.sv ====
`timescale 1ns/1ps

module spi_peripheral (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sclk,
    input  logic               mosi,
    input  logic               ss,
    output logic               miso,
    input  vga_pkg::cfg_word_u tx_cfg,
    output logic [7:0]         byte_data,
    output logic               byte_valid,
    output logic               frame_end
);
    logic [2:0]  sclk_s;     // [1] synced, [2] one older
    logic [2:0]  ss_s;
    logic [1:0]  mosi_s;     // Same depth as sclk
    logic [6:0]  rx_shift;   // Bits so far
    logic [2:0]  bit_cnt;
    logic [31:0] tx_shift;   // Readback shadow
    logic        sclk_rise;
    logic        sclk_fall;
    logic        ss_fall;
    logic        ss_rise;

    assign sclk_rise = sclk_s[1] & ~sclk_s[2];
    assign sclk_fall = ~sclk_s[1] & sclk_s[2];
    assign ss_fall   = ~ss_s[1] & ss_s[2];
    assign ss_rise   = ss_s[1] & ~ss_s[2];
    assign miso      = tx_shift[31];  // MSB first

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_s <= 3'b000;
            ss_s   <= 3'b111;  // Deselected
            mosi_s <= 2'b00;
        end else begin
            sclk_s <= {sclk_s[1:0], sclk};
            ss_s   <= {ss_s[1:0], ss};
            mosi_s <= {mosi_s[0], mosi};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= 3'd0;
            byte_valid <= 1'b0;
            frame_end  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_end  <= ss_rise;  // Third clk after pin edge
            if (ss_s[1]) begin
                bit_cnt <= 3'd0;  // Realign on every select
            end else if (sclk_rise) begin
                bit_cnt    <= bit_cnt + 3'd1;
                byte_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ss_s[1] && sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_s[1]};
            if (bit_cnt == 3'd7) begin
                byte_data <= {rx_shift, mosi_s[1]};  // Eighth bit
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= 32'd0;
        end else if (ss_fall) begin
            tx_shift <= tx_cfg;  // Snapshot of active word
        end else if (!ss_s[1] && sclk_fall) begin
            tx_shift <= {tx_shift[30:0], 1'b0};  // Mode 0, shift on fall
        end
    end

    a_byte_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |-> !ss_s[1]);

endmodule

// ==== hw/config_manager.sv ====
`timescale 1ns/1ps

module config_manager (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         byte_data,
    input  logic               byte_valid,
    input  logic               frame_end,
    output vga_pkg::cfg_word_u active_cfg
);
    vga_pkg::cfg_word_u pending;   // Word being assembled
    logic [2:0]         byte_cnt;  // Saturates at 7

    always_ff @(posedge clk) begin
        if (byte_valid && (byte_cnt < 3'd4)) begin
            pending.bytes[2'd3 - byte_cnt[1:0]] <= byte_data;  // Byte 3 first
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt   <= 3'd0;
            active_cfg <= vga_pkg::CFG_RESET;
        end else if (frame_end) begin
            if (byte_cnt == 3'd4) begin
                active_cfg <= pending;  // Exactly four bytes only
            end
            byte_cnt <= 3'd0;
        end else if (byte_valid && (byte_cnt != 3'd7)) begin
            byte_cnt <= byte_cnt + 3'd1;
        end
    end

    a_commit_on_end: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(active_cfg) |-> $past(frame_end));

endmodule

// ==== hw/char_renderer.sv ====
`timescale 1ns/1ps

module char_renderer (
    vga_beam_if.sink           beam,
    input  vga_pkg::cfg_word_u cfg,
    output logic               char_on
);
    logic [9:0]  sx;        // Scaled column
    logic [9:0]  sy;        // Scaled row
    logic [9:0]  cell_x;    // Cell index across
    logic [2:0]  px;        // Column inside cell
    logic [2:0]  py;        // Row inside cell
    logic [3:0]  digit;
    logic [19:0] glyph;
    logic [3:0]  row_bits;

    // Rows top to bottom, MSB is leftmost pixel
    function automatic logic [19:0] hex_glyph(input logic [3:0] d);
        case (d)
            4'h0:    hex_glyph = 20'hF999F;
            4'h1:    hex_glyph = 20'h26227;
            4'h2:    hex_glyph = 20'hF1F8F;
            4'h3:    hex_glyph = 20'hF1F1F;
            4'h4:    hex_glyph = 20'h99F11;
            4'h5:    hex_glyph = 20'hF8F1F;
            4'h6:    hex_glyph = 20'hF8F9F;
            4'h7:    hex_glyph = 20'hF1244;
            4'h8:    hex_glyph = 20'hF9F9F;
            4'h9:    hex_glyph = 20'hF9F1F;
            4'hA:    hex_glyph = 20'h69F99;
            4'hB:    hex_glyph = 20'hE9E9E;
            4'hC:    hex_glyph = 20'hF888F;
            4'hD:    hex_glyph = 20'hE999E;
            4'hE:    hex_glyph = 20'hF8E8F;
            default: hex_glyph = 20'hF8E88;
        endcase
    endfunction

    assign sx     = beam.x >> cfg.f.scale;  // Power-of-two zoom
    assign sy     = beam.y >> cfg.f.scale;
    assign cell_x = sx / 10'd6;              // 6x6 cells
    assign px     = 3'(sx % 10'd6);
    assign py     = 3'(sy % 10'd6);
    assign digit  = cell_x[0] ? cfg.f.char_code[3:0] : cfg.f.char_code[7:4];  // Even cell high
    assign glyph  = hex_glyph(digit);

    always_comb begin
        row_bits = 4'h0;  // Gap row
        if (py < 3'd5) begin
            row_bits = 4'(glyph >> (5'd16 - {py, 2'b00}));
        end
    end

    assign char_on = (px < 3'd4) && row_bits[2'd3 - px[1:0]];  // Gap column off

endmodule

// ==== hw/pong_game.sv ====
`timescale 1ns/1ps

module pong_game #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic      clk,
    input  logic      rst_n,
    vga_beam_if.sink  beam,
    input  logic      btn_up,
    input  logic      btn_down,
    output logic      pong_on
);
    localparam logic [9:0] PAD_W    = 10'(vga_pkg::PADDLE_W);
    localparam logic [9:0] PAD_H    = 10'(vga_pkg::PADDLE_H);
    localparam logic [9:0] STEP     = 10'(vga_pkg::PADDLE_STEP);
    localparam logic [9:0] BALL     = 10'(vga_pkg::BALL_SIZE);
    localparam logic [9:0] PAD_MAX  = 10'(V_VISIBLE - vga_pkg::PADDLE_H);
    localparam logic [9:0] BALL_XR  = 10'(H_VISIBLE - vga_pkg::BALL_SIZE);  // Right wall
    localparam logic [9:0] BALL_YB  = 10'(V_VISIBLE - vga_pkg::BALL_SIZE);  // Bottom wall
    localparam logic [9:0] X_CENTRE = 10'(H_VISIBLE / 2);
    localparam logic [9:0] Y_CENTRE = 10'(V_VISIBLE / 2);

    logic [9:0] paddle_y;  // Paddle top
    logic [9:0] ball_x;    // Ball top left
    logic [9:0] ball_y;
    logic       dir_x;     // 1 moves right
    logic       dir_y;     // 1 moves down
    logic       pad_hit;

    assign pad_hit = (ball_y + BALL > paddle_y) && (ball_y < paddle_y + PAD_H);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddle_y <= PAD_MAX >> 1;  // Centred
            ball_x   <= X_CENTRE;
            ball_y   <= Y_CENTRE;
            dir_x    <= 1'b0;  // Serve toward paddle
            dir_y    <= 1'b1;
        end else if (beam.frame_start) begin
            if (btn_up && !btn_down) begin
                paddle_y <= (paddle_y < STEP) ? 10'd0 : paddle_y - STEP;
            end else if (btn_down && !btn_up) begin
                paddle_y <= (paddle_y + STEP > PAD_MAX) ? PAD_MAX : paddle_y + STEP;
            end

            if (ball_x == 10'd0) begin  // Missed, respawn
                ball_x <= X_CENTRE;
                ball_y <= Y_CENTRE;
            end else begin
                if (dir_x && (ball_x >= BALL_XR)) begin
                    dir_x  <= 1'b0;
                    ball_x <= ball_x - 10'd1;
                end else if (!dir_x && (ball_x == PAD_W) && pad_hit) begin
                    dir_x  <= 1'b1;  // Paddle return
                    ball_x <= ball_x + 10'd1;
                end else begin
                    ball_x <= dir_x ? ball_x + 10'd1 : ball_x - 10'd1;
                end

                if (dir_y && (ball_y >= BALL_YB)) begin
                    dir_y  <= 1'b0;
                    ball_y <= ball_y - 10'd1;
                end else if (!dir_y && (ball_y == 10'd0)) begin
                    dir_y  <= 1'b1;
                    ball_y <= ball_y + 10'd1;
                end else begin
                    ball_y <= dir_y ? ball_y + 10'd1 : ball_y - 10'd1;
                end
            end
        end
    end

    assign pong_on = ((beam.x < PAD_W) && (beam.y >= paddle_y)
                      && (beam.y < paddle_y + PAD_H))
                   || ((beam.x >= ball_x) && (beam.x < ball_x + BALL)
                      && (beam.y >= ball_y) && (beam.y < ball_y + BALL));

endmodule

// ==== hw/pixel_mixer.sv ====
`timescale 1ns/1ps

module pixel_mixer (
    input  logic               clk,
    input  logic               rst_n,
    vga_beam_if.sink           beam,
    input  vga_pkg::cfg_word_u cfg,
    input  logic               char_on,
    input  logic               pong_on,
    output vga_pkg::cfg_word_u frame_cfg,
    output logic [5:0]         rgb,
    output logic               hsync,
    output logic               vsync
);
    vga_pkg::cfg_word_u cfg_q;  // Word held for the frame
    logic [11:0]        lfsr;
    logic               use_fg;
    logic               vis_q;

    // Pixel 0,0 already sees the new word
    assign frame_cfg = beam.frame_start ? cfg : cfg_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= vga_pkg::CFG_RESET;
            lfsr  <= 12'h001;  // Any nonzero seed
        end else begin
            if (beam.frame_start) begin
                cfg_q <= cfg;
            end
            lfsr <= {lfsr[10:0], lfsr[11] ^ lfsr[10] ^ lfsr[9] ^ lfsr[3]};  // Maximal taps
        end
    end

    always_comb begin
        case (frame_cfg.f.mode)
            vga_pkg::MODE_SOLID: use_fg = 1'b0;
            vga_pkg::MODE_CHAR:  use_fg = char_on;
            vga_pkg::MODE_PONG:  use_fg = pong_on;
            default:             use_fg = lfsr[0];  // Noise
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb   <= 6'd0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            vis_q <= 1'b0;
        end else begin
            rgb   <= !beam.visible ? 6'd0 : (use_fg ? frame_cfg.f.fg : frame_cfg.f.bg);
            hsync <= beam.hsync;  // Same stage as colour
            vsync <= beam.vsync;
            vis_q <= beam.visible;
        end
    end

    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        !vis_q |-> (rgb == 6'd0));

endmodule

// ==== hw/vga_demo_top.sv ====
`timescale 1ns/1ps

module vga_demo_top #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic [7:0] ui_in,    // SPI and buttons
    output logic [7:0] uo_out,   // Tiny VGA pinout
    input  logic [7:0] uio_in,   // Unused
    output logic [7:0] uio_out,  // miso on bit 0
    output logic [7:0] uio_oe,
    input  logic       ena,      // Ignored
    input  logic       clk,
    input  logic       rst_n
);
    vga_beam_if         beam ();
    vga_pkg::cfg_word_u active_cfg;  // Committed word
    vga_pkg::cfg_word_u frame_cfg;   // Word in use this frame
    logic [7:0]         byte_data;
    logic               byte_valid;
    logic               frame_end;
    logic               char_on;
    logic               pong_on;
    logic [5:0]         rgb;         // R1 R0 G1 G0 B1 B0
    logic               hsync;
    logic               vsync;

    vga_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_timing (.clk(clk), .rst_n(rst_n), .beam(beam.source));

    spi_peripheral i_spi (
        .clk(clk), .rst_n(rst_n),
        .sclk(ui_in[1]), .mosi(ui_in[0]), .ss(ui_in[2]),
        .miso(uio_out[0]), .tx_cfg(active_cfg),
        .byte_data(byte_data), .byte_valid(byte_valid), .frame_end(frame_end)
    );

    config_manager i_cfg (
        .clk(clk), .rst_n(rst_n),
        .byte_data(byte_data), .byte_valid(byte_valid), .frame_end(frame_end),
        .active_cfg(active_cfg)
    );

    char_renderer i_char (.beam(beam.sink), .cfg(frame_cfg), .char_on(char_on));

    pong_game #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)) i_pong (
        .clk(clk), .rst_n(rst_n), .beam(beam.sink),
        .btn_up(ui_in[4]), .btn_down(ui_in[5]), .pong_on(pong_on)
    );

    pixel_mixer i_mixer (
        .clk(clk), .rst_n(rst_n), .beam(beam.sink), .cfg(active_cfg),
        .char_on(char_on), .pong_on(pong_on), .frame_cfg(frame_cfg),
        .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

    // hsync B0 G0 R0 vsync B1 G1 R1, MSB first
    assign uo_out       = {hsync, rgb[0], rgb[2], rgb[4], vsync, rgb[1], rgb[3], rgb[5]};
    assign uio_out[7:1] = 7'd0;
    assign uio_oe       = 8'h01;  // Only miso drives

endmodule

// ==== test/tb_vga_demo.sv ====
`timescale 1ns/1ps

module tb_vga_demo;
    localparam int          FRAME_CYCLES = 80 * 54;  // Line total times line count
    localparam int          HOLD_FRAMES  = (48 - vga_pkg::PADDLE_H) / vga_pkg::PADDLE_STEP + 4;
    localparam logic [31:0] RESET_WORD   = {2'b01, 6'h3F, 6'h00, 8'h00, 2'b00, 8'h00};

    logic               clk = 1'b0;
    logic               rst_n;
    logic [7:0]         ui_in;       // ss 2, sclk 1, mosi 0, down 5, up 4
    logic [7:0]         uio_in;
    logic               ena;
    logic [7:0]         uo_out;
    logic [7:0]         uio_out;
    logic [7:0]         uio_oe;
    logic [31:0]        rnd;         // xorshift state
    vga_pkg::cfg_word_u exp_cfg;     // Expected committed word
    vga_pkg::cfg_word_u cfg_d1;
    vga_pkg::cfg_word_u fr_cfg;      // Word of the tracked frame
    logic [31:0]        rd_word;     // Last miso capture
    logic               rd_done;
    logic [1:0]         pong_phase;  // 1 paddle at top, 2 at bottom
    logic [5:0]         pix_q;       // Sampled colour
    logic               hs_q;
    logic               vs_q;
    logic [6:0]         ox;          // Tracked column of pix_q
    logic [5:0]         oy;
    logic               locked;
    logic               full_frame;  // Whole frame seen since lock
    logic               frame_tick;
    logic               seen_fg;
    logic               seen_bg;
    logic               in_vis;
    logic               exp_hs;
    logic               exp_vs;

    always #50 clk = ~clk;

    vga_demo_top #(
        .H_VISIBLE(64), .H_FRONT(4), .H_SYNC(8), .H_BACK(4),
        .V_VISIBLE(48), .V_FRONT(2), .V_SYNC(2), .V_BACK(2)
    ) i_dut (
        .ui_in(ui_in), .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out),
        .uio_oe(uio_oe), .ena(ena), .clk(clk), .rst_n(rst_n)
    );

    // R1 R0 G1 G0 B1 B0 from the tiny VGA pinout
    function automatic logic [5:0] pin_colour(input logic [7:0] p);
        return {p[0], p[4], p[1], p[5], p[2], p[6]};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic vga_pkg::cfg_word_u make_word(input vga_pkg::mode_e mode,
                                                     input logic [31:0] r);
        vga_pkg::cfg_word_u w;
        w        = r;
        w.f.mode = mode;
        w.f.bg   = ~w.f.fg;  // Colours always differ
        return w;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        stop_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, want));
    endtask

    task automatic wait_lock();
        int guard;
        guard = 0;
        while (!locked) begin
            @(posedge clk);
            guard++;
            if (guard > 2 * FRAME_CYCLES) stop_run("No vsync pulse seen on uo_out");
        end
    endtask

    task automatic wait_frames(input int n);
        int count;
        int guard;
        count = 0;
        guard = 0;
        while (count < n) begin
            @(posedge clk);
            guard++;
            if (frame_tick) count++;
            if (guard > (n + 1) * FRAME_CYCLES) stop_run("Timed out waiting for a frame");
        end
    endtask

    // Mode 0 master, sclk toggles every 4 clk, miso sampled at each rise
    task automatic spi_write(input vga_pkg::cfg_word_u w, input int nbytes);
        logic [31:0] bits;
        logic [31:0] rd;
        bits = w;
        rd   = 32'd0;
        @(posedge clk);
        ui_in[2] <= 1'b0;
        repeat (6) @(posedge clk);  // Shadow loads after ss falls
        for (int i = 0; i < nbytes * 8; i++) begin
            ui_in[0] <= bits[31 - i];
            repeat (4) @(posedge clk);
            rd[31 - i] = uio_out[0];
            ui_in[1]  <= 1'b1;
            repeat (4) @(posedge clk);
            ui_in[1] <= 1'b0;
        end
        repeat (4) @(posedge clk);
        ui_in[2] <= 1'b1;
        rd_word  <= rd;
        rd_done  <= (nbytes == 4);  // Full readback only
        @(posedge clk);
        rd_done <= 1'b0;
        repeat (3) @(posedge clk);  // Commit lands 4 clk after ss rise
        if (nbytes == 4) exp_cfg <= w;
    endtask

    assign in_vis = (ox < 7'd64) && (oy < 6'd48);
    assign exp_hs = !((ox >= 7'd68) && (ox < 7'd76));
    assign exp_vs = !((oy >= 6'd50) && (oy < 6'd52));  // Two whole lines

    // Beam position of the sampled pin values, locked on the first vsync fall
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_q      <= 6'd0;
            hs_q       <= 1'b1;
            vs_q       <= 1'b1;
            ox         <= 7'd0;
            oy         <= 6'd0;
            locked     <= 1'b0;
            full_frame <= 1'b0;
            frame_tick <= 1'b0;
            seen_fg    <= 1'b0;
            seen_bg    <= 1'b0;
            cfg_d1     <= RESET_WORD;
            fr_cfg     <= RESET_WORD;
        end else begin
            pix_q      <= pin_colour(uo_out);
            hs_q       <= uo_out[7];
            vs_q       <= uo_out[3];
            cfg_d1     <= exp_cfg;  // Output lags the beam
            frame_tick <= 1'b0;
            if (!locked && !uo_out[3] && vs_q) begin
                locked <= 1'b1;
                ox     <= 7'd0;
                oy     <= 6'd50;  // First vsync line
            end else if (ox == 7'd79) begin
                ox <= 7'd0;
                oy <= (oy == 6'd53) ? 6'd0 : oy + 6'd1;
                if (oy == 6'd53) begin
                    frame_tick <= locked;
                    full_frame <= locked;
                    fr_cfg     <= cfg_d1;  // Word taken at frame start
                end
            end else begin
                ox <= ox + 7'd1;
            end
            if (frame_tick) begin
                seen_fg <= (pix_q == fr_cfg.f.fg);
                seen_bg <= (pix_q == fr_cfg.f.bg);
            end else if (in_vis) begin
                seen_fg <= seen_fg | (pix_q == fr_cfg.f.fg);
                seen_bg <= seen_bg | (pix_q == fr_cfg.f.bg);
            end
        end
    end

    a_hsync: assert property (@(posedge clk) disable iff (!rst_n)
        locked |-> (hs_q == exp_hs))
        else report_mismatch("hsync", 32'($sampled(hs_q)), 32'($sampled(exp_hs)));
    a_vsync: assert property (@(posedge clk) disable iff (!rst_n)
        locked |-> (vs_q == exp_vs))
        else report_mismatch("vsync", 32'($sampled(vs_q)), 32'($sampled(exp_vs)));
    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (locked && !in_vis) |-> (pix_q == 6'd0))
        else report_mismatch("rgb", 32'($sampled(pix_q)), 32'd0);
    a_solid: assert property (@(posedge clk) disable iff (!rst_n)
        (full_frame && in_vis && (fr_cfg.f.mode == vga_pkg::MODE_SOLID))
        |-> (pix_q == fr_cfg.f.bg))
        else report_mismatch("rgb", 32'($sampled(pix_q)), 32'(fr_cfg.f.bg));
    a_two_colour: assert property (@(posedge clk) disable iff (!rst_n)
        (full_frame && in_vis && ((fr_cfg.f.mode == vga_pkg::MODE_CHAR)
        || (fr_cfg.f.mode == vga_pkg::MODE_NOISE)))
        |-> ((pix_q == fr_cfg.f.fg) || (pix_q == fr_cfg.f.bg)))
        else report_mismatch("rgb", 32'($sampled(pix_q)), 32'(fr_cfg.f.fg));
    a_both_seen: assert property (@(posedge clk) disable iff (!rst_n)
        (full_frame && (ox == 7'd0) && (oy == 6'd48) && ((fr_cfg.f.mode == vga_pkg::MODE_CHAR)
        || (fr_cfg.f.mode == vga_pkg::MODE_NOISE))) |-> (seen_fg && seen_bg))
        else stop_run("A char or noise frame did not show both colours");
    a_paddle_top: assert property (@(posedge clk) disable iff (!rst_n)
        ((pong_phase == 2'd1) && full_frame && (ox == 7'd0) && (oy == 6'd0))
        |-> (pix_q == fr_cfg.f.fg))
        else report_mismatch("rgb", 32'($sampled(pix_q)), 32'(fr_cfg.f.fg));
    a_paddle_bottom: assert property (@(posedge clk) disable iff (!rst_n)
        ((pong_phase == 2'd2) && full_frame && (ox == 7'd0) && (oy == 6'd47))
        |-> (pix_q == fr_cfg.f.fg))
        else report_mismatch("rgb", 32'($sampled(pix_q)), 32'(fr_cfg.f.fg));
    a_paddle_gone: assert property (@(posedge clk) disable iff (!rst_n)
        ((pong_phase == 2'd2) && full_frame && (ox == 7'd0) && (oy == 6'd0))
        |-> (pix_q == fr_cfg.f.bg))
        else report_mismatch("rgb", 32'($sampled(pix_q)), 32'(fr_cfg.f.bg));
    a_readback: assert property (@(posedge clk) disable iff (!rst_n)
        rd_done |-> (rd_word == exp_cfg))
        else report_mismatch("miso word", $sampled(rd_word), exp_cfg);
    a_uio_oe: assert property (@(posedge clk) uio_oe == 8'h01)
        else report_mismatch("uio_oe", 32'($sampled(uio_oe)), 32'h01);
    a_uio_out: assert property (@(posedge clk) uio_out[7:1] == 7'd0)
        else report_mismatch("uio_out", 32'($sampled(uio_out[7:1])), 32'd0);

    initial begin
        rst_n      <= 1'b0;
        ui_in      <= 8'h04;  // ss idle high
        uio_in     <= 8'h00;
        ena        <= 1'b1;
        rd_word    <= 32'd0;
        rd_done    <= 1'b0;
        pong_phase <= 2'd0;
        exp_cfg    <= RESET_WORD;
        rnd = 32'd81049;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait_lock();
        wait_frames(2);  // Reset word in char mode
        rnd = xorshift(rnd);
        spi_write(make_word(vga_pkg::MODE_CHAR, rnd), 4);
        wait_frames(2);
        rnd = xorshift(rnd);
        spi_write(make_word(vga_pkg::MODE_NOISE, rnd), 4);
        wait_frames(2);
        rnd = xorshift(rnd);
        spi_write(make_word(vga_pkg::MODE_SOLID, rnd), 3);  // Dropped, noise stays
        wait_frames(2);
        rnd = xorshift(rnd);
        spi_write(make_word(vga_pkg::MODE_SOLID, rnd), 4);
        wait_frames(2);
        rnd = xorshift(rnd);
        spi_write(make_word(vga_pkg::MODE_PONG, rnd), 4);
        ui_in[4] <= 1'b1;
        wait_frames(HOLD_FRAMES);
        pong_phase <= 2'd1;
        wait_frames(2);
        pong_phase <= 2'd0;
        ui_in[4]   <= 1'b0;
        ui_in[5]   <= 1'b1;
        wait_frames(HOLD_FRAMES);
        pong_phase <= 2'd2;
        wait_frames(2);
        pong_phase <= 2'd0;
        ui_in[5]   <= 1'b0;
        rnd = xorshift(rnd);
        spi_write(make_word(vga_pkg::MODE_CHAR, rnd), 4);  // Reads back the pong word
        wait_frames(2);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== files.f ====
hw/vga_pkg.sv
hw/vga_beam_if.sv
hw/vga_timing.sv
hw/spi_peripheral.sv
hw/config_manager.sv
hw/char_renderer.sv
hw/pong_game.sv
hw/pixel_mixer.sv
hw/vga_demo_top.sv
test/tb_vga_demo.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_vga_demo
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
